// ==== Makefile ====
# Verilator build and run for the instruction-fetch subsystem

TOP := fetch_top_tb
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fetch_top.f

# fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== fetch_top.f ====
src/fetch_pkg.sv
src/ibus_if.sv
src/fetch_dec_if.sv
src/insn_mem.sv
src/fetch_unit.sv
src/decode_stage.sv
src/fetch_top.sv
tests/fetch_top_chk.sv
tests/fetch_top_tb.sv

// ==== src/decode_stage.sv ====
/*
 * Decode stage.
 * Opcode decode, jump and bus error redirects, discard of stale
 * words while a redirect is pending, retire registers.
 */

module decode_stage import fetch_pkg::*; #(
   parameter int ADDR_W = fetch_pkg::ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   fetch_dec_if.decode       dec,
   input  logic              padv_i,
   input  logic              restart_i,
   output logic              branch_occur_o,
   output logic [ADDR_W-1:0] branch_dest_o,
   output logic              retire_valid_o,
   output logic [ADDR_W-1:0] retire_pc_o,
   output logic [INSN_W-1:0] retire_insn_o,
   output logic              retire_err_o
);

   opcode_t           op;
   logic [25:0]       j_off;
   logic [ADDR_W-1:0] j_target;

   logic              consume;
   logic              take;
   logic              redirect;

   always_comb begin
      case (dec.insn[INSN_W-1 -: 6])
         OP_J:    op = OP_J;
         OP_NOP:  op = OP_NOP;
         default: op = OP_OTHER;
      endcase
   end

   // pc-relative, offset counts words
   assign j_off    = dec.insn[25:0];
   assign j_target = dec.pc + {{(ADDR_W - 28){j_off[25]}}, j_off, 2'b00};

   // a word in the restart cycle is dropped, fetch restarts anyway
   assign consume = dec.valid && padv_i && !restart_i;

   // while a redirect is pending only the target word gets through
   assign take     = consume && (!branch_occur_o || dec.branch_taken);
   assign redirect = take && (dec.ibus_err || op == OP_J);

   always_ff @(posedge clk) begin
      if (rst) begin
         branch_occur_o <= 1'b0;
         retire_valid_o <= 1'b0;
      end else begin
         retire_valid_o <= take;
         if (restart_i) begin
            branch_occur_o <= 1'b0;
         end else if (redirect) begin
            // a target that jumps again keeps the request up
            branch_occur_o <= 1'b1;
         end else if (consume && dec.branch_taken) begin
            branch_occur_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (redirect) begin
         branch_dest_o <= dec.ibus_err ? EXC_VECTOR : j_target;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         retire_pc_o   <= dec.pc;
         retire_insn_o <= dec.insn;
         retire_err_o  <= dec.ibus_err;
      end
   end

endmodule

// ==== src/fetch_dec_if.sv ====
/*
 * Fetch to decode handoff.
 * Fetch and decode modports.
 */

interface fetch_dec_if import fetch_pkg::*; ();

   // word waiting for the decode stage, taken while padv is high
   logic              valid;
   logic [ADDR_W-1:0] pc;
   logic [INSN_W-1:0] insn;

   // fetch of this word failed, insn is then a nop
   logic              ibus_err;

   // first word fetched from a redirect target
   logic              branch_taken;

   modport fetch (
      output valid, pc, insn, ibus_err, branch_taken
   );

   modport decode (
      input  valid, pc, insn, ibus_err, branch_taken
   );

endinterface

// ==== src/fetch_pkg.sv ====
/*
 * Shared definitions for the instruction-fetch subsystem.
 * Address and instruction widths, reset and exception vectors,
 * opcode and fetch FSM state enums.
 */

package fetch_pkg;

   // bus and datapath widths
   localparam int ADDR_W = 32;
   localparam int INSN_W = 32;

   // first fetch after reset
   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0100;

   // redirect target after an instruction bus error
   localparam logic [ADDR_W-1:0] EXC_VECTOR = 32'h0000_0200;

   // major opcode in insn[31:26]
   // OP_J carries a signed 26-bit word offset relative to its own pc
   // any encoding other than OP_J and OP_NOP is treated as OP_OTHER
   typedef enum logic [5:0] {
      OP_J     = 6'h00,
      OP_NOP   = 6'h05,
      OP_OTHER = 6'h3f
   } opcode_t;

   // fetch unit FSM
   typedef enum logic [2:0] {
      INIT,
      LOAD_REQ,
      ADVANCE,
      STALL,
      BRANCH_WAITBUS,
      BRANCH,
      BRANCH_DONE
   } fetch_state_t;

endpackage

// ==== src/fetch_top.sv ====
/*
 * Instruction-fetch subsystem top level.
 * Instruction memory, fetch unit and decode stage on plain ports.
 */

module fetch_top import fetch_pkg::*; #(
   parameter int                MEM_WAIT = 1,
   parameter logic [ADDR_W-1:0] ERR_BASE = 32'h0000_1000,
   parameter int                DEPTH    = 1024
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              stall_i,
   input  logic              restart_i,
   input  logic [ADDR_W-1:0] restart_pc_i,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [INSN_W-1:0] wr_data_i,
   output logic              retire_valid_o,
   output logic [ADDR_W-1:0] retire_pc_o,
   output logic [INSN_W-1:0] retire_insn_o,
   output logic              retire_err_o
);

   ibus_if      ibus ();
   fetch_dec_if fd ();

   logic              padv;
   logic              branch_occur;
   logic [ADDR_W-1:0] branch_dest;

   // pipeline advances whenever nothing holds it
   assign padv = ~stall_i;

   insn_mem #(
      .DEPTH    (DEPTH),
      .MEM_WAIT (MEM_WAIT),
      .ERR_BASE (ERR_BASE)
   ) u_mem (
      .clk       (clk),
      .rst       (rst),
      .ibus      (ibus.slave),
      .wr_en_i   (wr_en_i),
      .wr_addr_i (wr_addr_i),
      .wr_data_i (wr_data_i)
   );

   fetch_unit #(
      .ADDR_W   (ADDR_W),
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .clk            (clk),
      .rst            (rst),
      .ibus           (ibus.master),
      .dec            (fd.fetch),
      .padv_i         (padv),
      .branch_occur_i (branch_occur),
      .branch_dest_i  (branch_dest),
      .restart_i      (restart_i),
      .restart_pc_i   (restart_pc_i)
   );

   decode_stage #(
      .ADDR_W (ADDR_W)
   ) u_decode (
      .clk            (clk),
      .rst            (rst),
      .dec            (fd.decode),
      .padv_i         (padv),
      .restart_i      (restart_i),
      .branch_occur_o (branch_occur),
      .branch_dest_o  (branch_dest),
      .retire_valid_o (retire_valid_o),
      .retire_pc_o    (retire_pc_o),
      .retire_insn_o  (retire_insn_o),
      .retire_err_o   (retire_err_o)
   );

endmodule

// ==== src/fetch_unit.sv ====
/*
 * Fetch unit.
 * Seven-state fetch FSM, fetch address register, handoff registers
 * for insn and pc, and the sticky bus error flag.
 * Reacts to redirects, pipeline stalls and debug restarts.
 */

module fetch_unit import fetch_pkg::*; #(
   parameter int                ADDR_W   = fetch_pkg::ADDR_W,
   parameter logic [ADDR_W-1:0] RESET_PC = fetch_pkg::RESET_PC
) (
   input  logic              clk,
   input  logic              rst,
   ibus_if.master            ibus,
   fetch_dec_if.fetch        dec,
   input  logic              padv_i,
   input  logic              branch_occur_i,
   input  logic [ADDR_W-1:0] branch_dest_i,
   input  logic              restart_i,
   input  logic [ADDR_W-1:0] restart_pc_i
);

   // word handed to decode in place of a failed fetch
   localparam logic [INSN_W-1:0] NOP_INSN = {OP_NOP, {(INSN_W - 6){1'b0}}};

   fetch_state_t      state;
   fetch_state_t      pre_stall_state;

   logic [ADDR_W-1:0] pc_addr;
   logic [ADDR_W-1:0] pc_addr_next;

   logic              done;
   logic              stall_enter;
   logic              present;
   logic              accept_redirect;
   logic              consume;

   assign done         = ibus.ack | ibus.err;
   assign pc_addr_next = pc_addr + ADDR_W'(4);
   assign ibus.adr     = pc_addr;

   // INIT, LOAD_REQ and STALL run on their own while padv is low
   assign stall_enter = !padv_i && (state != STALL) && (state != LOAD_REQ) &&
                        (state != INIT);

   // completed access that becomes the next word for decode
   assign present = padv_i && !restart_i && done &&
                    ((state == ADVANCE && !branch_occur_i) ||
                     (state == BRANCH) || (state == BRANCH_DONE));

   // completed access that is dropped in favour of the redirect target
   assign accept_redirect = padv_i && !restart_i && done &&
                            ((state == ADVANCE && branch_occur_i) ||
                             (state == BRANCH_WAITBUS));

   assign consume = dec.valid && padv_i;

   always_ff @(posedge clk) begin
      if (rst) begin
         state           <= INIT;
         pre_stall_state <= ADVANCE;
         ibus.req        <= 1'b0;
         pc_addr         <= RESET_PC;
      end else if (restart_i) begin
         // debug restart wins over everything else
         // req drops so that the open access is abandoned cleanly
         state           <= LOAD_REQ;
         pre_stall_state <= ADVANCE;
         ibus.req        <= 1'b0;
         pc_addr         <= restart_pc_i;
      end else if (stall_enter) begin
         // addresses freeze, data of a completing access is thrown away
         pre_stall_state <= state;
         state           <= STALL;
         if (done) begin
            ibus.req <= 1'b0;
         end
      end else begin
         case (state)
            INIT: begin
               state <= LOAD_REQ;
            end

            LOAD_REQ: begin
               ibus.req <= 1'b1;
               state    <= pre_stall_state;
            end

            ADVANCE: begin
               if (branch_occur_i) begin
                  if (done) begin
                     pc_addr <= branch_dest_i;
                     state   <= BRANCH;
                  end else begin
                     // let the open access finish first
                     state <= BRANCH_WAITBUS;
                  end
               end else if (done) begin
                  pc_addr <= pc_addr_next;
               end
            end

            STALL: begin
               if (ibus.req) begin
                  if (done) begin
                     ibus.req <= 1'b0;
                  end
               end else if (padv_i) begin
                  // pc_addr still points at the first word not yet taken
                  state <= LOAD_REQ;
               end
            end

            BRANCH_WAITBUS: begin
               if (done) begin
                  pc_addr <= branch_dest_i;
                  state   <= BRANCH;
               end
            end

            BRANCH: begin
               if (done) begin
                  pc_addr <= pc_addr_next;
                  state   <= BRANCH_DONE;
               end
            end

            BRANCH_DONE: begin
               // branch_occur_i is stale while the target word is in decode
               if (done) begin
                  pc_addr <= pc_addr_next;
               end
               state <= ADVANCE;
            end

            default: begin
               state <= INIT;
            end
         endcase
      end
   end

   // handoff control
   always_ff @(posedge clk) begin
      if (rst || restart_i) begin
         dec.valid        <= 1'b0;
         dec.branch_taken <= 1'b0;
      end else if (present) begin
         dec.valid        <= 1'b1;
         dec.branch_taken <= (state == BRANCH);
      end else if (consume) begin
         dec.valid        <= 1'b0;
         dec.branch_taken <= 1'b0;
      end
   end

   // handoff payload
   always_ff @(posedge clk) begin
      if (present) begin
         dec.pc   <= pc_addr;
         dec.insn <= ibus.err ? NOP_INSN : ibus.dat;
      end
   end

   // sticky until the error redirect is taken up or a restart
   always_ff @(posedge clk) begin
      if (rst || restart_i) begin
         dec.ibus_err <= 1'b0;
      end else if (present && ibus.err) begin
         dec.ibus_err <= 1'b1;
      end else if (accept_redirect) begin
         dec.ibus_err <= 1'b0;
      end
   end

endmodule

// ==== src/ibus_if.sv ====
/*
 * Instruction bus between the fetch unit and the instruction memory.
 * Master and slave modports.
 */

interface ibus_if import fetch_pkg::*; ();

   // held high by the master for as long as it wants words
   logic              req;
   logic [ADDR_W-1:0] adr;

   // one-cycle completion pulses, dat valid with either
   logic              ack;
   logic              err;
   logic [INSN_W-1:0] dat;

   modport master (
      output req, adr,
      input  ack, err, dat
   );

   modport slave (
      input  req, adr,
      output ack, err, dat
   );

endinterface

// ==== src/insn_mem.sv ====
/*
 * Instruction memory on the instruction bus.
 * Word array with a write port, fixed wait-state counter,
 * error response above ERR_BASE.
 */

module insn_mem import fetch_pkg::*; #(
   parameter int                DEPTH    = 1024,
   parameter int                MEM_WAIT = 1,
   parameter logic [ADDR_W-1:0] ERR_BASE = 32'h0000_1000
) (
   input  logic              clk,
   input  logic              rst,
   ibus_if.slave             ibus,
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [INSN_W-1:0] wr_data_i
);

   localparam int IDX_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(MEM_WAIT + 2);

   logic [INSN_W-1:0] mem [DEPTH];

   logic [CNT_W-1:0]  wait_cnt;
   logic [IDX_W-1:0]  rd_idx;
   logic [IDX_W-1:0]  wr_idx;
   logic              issue;
   logic              in_err;

   // byte addresses, word aligned
   assign rd_idx = ibus.adr[IDX_W+1:2];
   assign wr_idx = wr_addr_i[IDX_W+1:2];

   assign in_err = (ibus.adr >= ERR_BASE);

   // no counting in the pulse cycle, the next access starts after it
   assign issue = ibus.req && !ibus.ack && !ibus.err &&
                  (wait_cnt == CNT_W'(MEM_WAIT));

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_idx] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wait_cnt <= '0;
         ibus.ack <= 1'b0;
         ibus.err <= 1'b0;
      end else begin
         ibus.ack <= issue && !in_err;
         ibus.err <= issue && in_err;
         if (!ibus.req || ibus.ack || ibus.err || issue) begin
            wait_cnt <= '0;
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

   // read data goes out together with the pulse
   always_ff @(posedge clk) begin
      if (issue) begin
         ibus.dat <= mem[rd_idx];
      end
   end

endmodule

// ==== tests/fetch_golden.txt ====
# prog <byte address hex> <insn hex> | test <name> <reset|restart> <start pc hex> <stall after n> <stall cycles>
# exp <retired pc hex> <retire_err>, listed in retire order below their test line
prog 100 8c000001
prog 104 14000000
prog 108 8c000002
prog 10c 0000000d
prog 110 8c000003
prog 140 8c000004
prog 144 00000003
prog 148 8c000005
prog 150 00000004
prog 160 8c000006
prog 164 8c000007
prog 168 000003a6
prog 16c 8c00000b
prog 200 8c000008
prog 204 14000000
prog 208 8c000009
test sequential reset 0 0 0
exp 100 0
exp 104 0
exp 108 0
test jump reset 0 0 0
exp 100 0
exp 104 0
exp 108 0
exp 10c 0
exp 140 0
exp 144 0
test restart_pending restart 200 0 0
exp 200 0
exp 204 0
exp 208 0
test back_to_back restart 144 0 0
exp 144 0
exp 150 0
exp 160 0
exp 164 0
test bus_error restart 164 0 0
exp 164 0
exp 168 0
exp 1000 1
exp 200 0
exp 204 0
test stall reset 0 2 6
exp 100 0
exp 104 0
exp 108 0
exp 10c 0
exp 140 0
test stall_jump restart 108 2 5
exp 108 0
exp 10c 0
exp 140 0
exp 144 0
exp 150 0
exp 160 0

// ==== tests/fetch_top_chk.sv ====
/*
 * Protocol assertions bound into the fetch unit.
 * Bus pulses, address hold, state after reset, FSM encoding.
 */

module fetch_top_chk import fetch_pkg::*; (
   input logic              clk,
   input logic              rst,
   input logic              req,
   input logic [ADDR_W-1:0] adr,
   input logic              ack,
   input logic              err,
   input logic              valid,
   input logic              branch_taken,
   input fetch_state_t      state
);

   // one pulse per access, never both kinds
   ack_err_excl: assert property (@(posedge clk) disable iff (rst) !(ack && err))
      else $error("ibus ack and err high in the same cycle");

   // address may move only after a pulse or with req dropping
   adr_hold: assert property (@(posedge clk) disable iff (rst)
      (req && !ack && !err) |=> (!req || $stable(adr)))
      else $error("ibus adr changed while an access was open");

   reset_quiet: assert property (@(posedge clk) rst |=> (!valid && !branch_taken))
      else $error("valid or branch_taken high right after reset");

   state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {INIT, LOAD_REQ, ADVANCE, STALL, BRANCH_WAITBUS, BRANCH, BRANCH_DONE})
      else $error("fetch FSM outside its encoding");

endmodule

bind fetch_unit fetch_top_chk u_chk (
   .clk          (clk),
   .rst          (rst),
   .req          (ibus.req),
   .adr          (ibus.adr),
   .ack          (ibus.ack),
   .err          (ibus.err),
   .valid        (dec.valid),
   .branch_taken (dec.branch_taken),
   .state        (state)
);

// ==== tests/fetch_top_tb.sv ====
/*
 * Testbench for the instruction-fetch subsystem.
 * Reads program words, test starts and expected retires from the
 * golden file, then runs each test and checks the retire stream.
 */

module fetch_top_tb import fetch_pkg::*; ();

   localparam int                MEM_WAIT = 2;
   localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_1000;
   localparam int                DEPTH    = 1024;
   localparam int                IDX_W    = $clog2(DEPTH);
   localparam int                TIMEOUT  = 200;

   logic              clk;
   logic              rst;
   logic              stall;
   logic              restart;
   logic [ADDR_W-1:0] restart_pc;
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [INSN_W-1:0] wr_data;
   logic              retire_valid;
   logic [ADDR_W-1:0] retire_pc;
   logic [INSN_W-1:0] retire_insn;
   logic              retire_err;

   // golden file contents
   logic [ADDR_W-1:0] prog_addr [$];
   logic [INSN_W-1:0] prog_data [$];
   logic [INSN_W-1:0] prog_word [DEPTH];
   logic [8*24-1:0]   test_name [$];
   bit                test_by_restart [$];
   logic [ADDR_W-1:0] test_pc [$];
   int                stall_after [$];
   int                stall_len [$];
   int                exp_first [$];
   int                exp_count [$];
   logic [ADDR_W-1:0] exp_pc [$];
   bit                exp_err [$];

   int                errors;
   int                tests_passed;
   int                tests_failed;

   fetch_top #(
      .MEM_WAIT (MEM_WAIT),
      .ERR_BASE (ERR_BASE),
      .DEPTH    (DEPTH)
   ) UUT (
      .clk            (clk),
      .rst            (rst),
      .stall_i        (stall),
      .restart_i      (restart),
      .restart_pc_i   (restart_pc),
      .wr_en_i        (wr_en),
      .wr_addr_i      (wr_addr),
      .wr_data_i      (wr_data),
      .retire_valid_o (retire_valid),
      .retire_pc_o    (retire_pc),
      .retire_insn_o  (retire_insn),
      .retire_err_o   (retire_err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // inputs change and outputs are read 2 units after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic read_golden(output bit ok);
      int              fd;
      int              n;
      logic [8*96-1:0] line;
      logic [8*24-1:0] kind;
      logic [8*24-1:0] name;
      logic [8*24-1:0] start;
      logic [31:0]     a;
      logic [31:0]     d;
      int              after;
      int              len;
      fd = $fopen("tests/fetch_golden.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while ($fgets(line, fd) != 0) begin
            kind = '0;
            n = $sscanf(line, "%s", kind);
            if (kind == "prog") begin
               n = $sscanf(line, "%s %h %h", kind, a, d);
               if (n != 3) begin
                  ok = 1'b0;
               end
               prog_addr.push_back(a);
               prog_data.push_back(d);
               prog_word[a[IDX_W+1:2]] = d;
            end else if (kind == "test") begin
               n = $sscanf(line, "%s %s %s %h %d %d", kind, name, start, a, after, len);
               if (n != 6) begin
                  ok = 1'b0;
               end
               test_name.push_back(name);
               test_by_restart.push_back(start == "restart");
               test_pc.push_back(a);
               stall_after.push_back(after);
               stall_len.push_back(len);
               exp_first.push_back(exp_pc.size());
               exp_count.push_back(0);
            end else if (kind == "exp" && exp_count.size() > 0) begin
               n = $sscanf(line, "%s %h %h", kind, a, d);
               if (n != 3) begin
                  ok = 1'b0;
               end
               exp_pc.push_back(a);
               exp_err.push_back(d[0]);
               exp_count[exp_count.size()-1]++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic load_program();
      for (int i = 0; i < prog_addr.size(); i++) begin
         wr_en   = 1'b1;
         wr_addr = prog_addr[i];
         wr_data = prog_data[i];
         next_cycle();
      end
      wr_en = 1'b0;
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (4) next_cycle();
      rst = 1'b0;
   endtask

   task automatic pulse_restart(input logic [ADDR_W-1:0] pc);
      restart    = 1'b1;
      restart_pc = pc;
      next_cycle();
      restart = 1'b0;
   endtask

   task automatic wait_retire(output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < TIMEOUT) begin
         next_cycle();
         seen = retire_valid;
         cycles++;
      end
   endtask

   // nothing may retire while the pipeline is held
   task automatic hold_stall(input int len, input logic [8*24-1:0] name);
      stall = 1'b1;
      for (int i = 0; i < len; i++) begin
         next_cycle();
         if (retire_valid) begin
            $display("test %0s: pc %h retired while stall_i was high", name, retire_pc);
            errors++;
         end
      end
      stall = 1'b0;
   endtask

   task automatic run_test(input int t);
      int                start_errors;
      int                got;
      int                e;
      bit                seen;
      logic [ADDR_W-1:0] pc_exp;
      logic [INSN_W-1:0] insn_exp;
      start_errors = errors;
      if (test_by_restart[t]) begin
         pulse_restart(test_pc[t]);
      end else begin
         apply_reset();
      end
      got  = 0;
      seen = 1'b1;
      while (seen && got < exp_count[t]) begin
         wait_retire(seen);
         if (!seen) begin
            $display("test %0s: no retire within %0d cycles after %0d retires",
                     test_name[t], TIMEOUT, got);
            errors++;
         end else begin
            e      = exp_first[t] + got;
            pc_exp = exp_pc[e];
            // a failed fetch retires as a nop
            insn_exp = exp_err[e] ? {OP_NOP, {(INSN_W - 6){1'b0}}} : prog_word[pc_exp[IDX_W+1:2]];
            if (retire_pc !== pc_exp) begin
               $display("CHECK FAILED %0s: retire_pc expected %h actual %h",
                        test_name[t], pc_exp, retire_pc);
               errors++;
            end
            if (retire_err !== exp_err[e]) begin
               $display("CHECK FAILED %0s: retire_err expected %h actual %h",
                        test_name[t], exp_err[e], retire_err);
               errors++;
            end
            if (retire_insn !== insn_exp) begin
               $display("CHECK FAILED %0s: retire_insn expected %h actual %h",
                        test_name[t], insn_exp, retire_insn);
               errors++;
            end
            got++;
            if (stall_len[t] > 0 && got == stall_after[t]) begin
               hold_stall(stall_len[t], test_name[t]);
            end
         end
      end
      if (errors == start_errors) begin
         $display("test %0s: passed, %0d retires checked", test_name[t], got);
         tests_passed++;
      end else begin
         $display("test %0s: failed with %0d errors", test_name[t], errors - start_errors);
         tests_failed++;
      end
   endtask

   initial begin
      bit loaded;
      rst          = 1'b1;
      stall        = 1'b0;
      restart      = 1'b0;
      restart_pc   = '0;
      wr_en        = 1'b0;
      wr_addr      = '0;
      wr_data      = '0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      read_golden(loaded);
      if (!loaded) begin
         $display("tests/fetch_golden.txt is missing or has a malformed line");
         errors++;
      end else if (test_name.size() == 0) begin
         $display("golden file holds no tests");
         errors++;
      end else begin
         // program goes in while the design is still in reset
         load_program();
         for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
         end
      end
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
